//--- logic/accel_pkg.sv
// ========================================
// Shared sizes, register map, host opcodes
// and scheduler state encoding
// ========================================
package accel_pkg;

    // Array and operand sizes
    localparam int N_ROWS = 2;
    localparam int N_COLS = 2;
    localparam int DATA_W = 8;
    localparam int ACC_W  = 32;

    // Buffer geometry
    localparam int BUF_DEPTH = 16;
    localparam int BUF_AW    = 4;
    localparam int K_W       = 5;

    // Host port widths
    localparam int CSR_AW = 8;
    localparam int REG_W  = 32;

    // ========================================
    // Register map
    // ========================================
    localparam logic [CSR_AW-1:0] REG_CTRL    = 8'h00;
    localparam logic [CSR_AW-1:0] REG_STATUS  = 8'h04;
    localparam logic [CSR_AW-1:0] REG_K_LEN   = 8'h08;
    localparam logic [CSR_AW-1:0] REG_BANK    = 8'h0C;
    localparam logic [CSR_AW-1:0] REG_RESULT0 = 8'h10;
    localparam logic [CSR_AW-1:0] REG_RESULT1 = 8'h14;
    localparam logic [CSR_AW-1:0] REG_RESULT2 = 8'h18;
    localparam logic [CSR_AW-1:0] REG_RESULT3 = 8'h1C;

    // Skew depth plus PE forwarding depth
    localparam int DRAIN_CYCLES = 4;

    typedef enum logic [1:0] {
        OP_REG_WR,
        OP_REG_RD,
        OP_ACT_WR,
        OP_WGT_WR
    } cmd_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_STREAM,
        ST_DRAIN,
        ST_DONE
    } sched_state_e;

endpackage

//--- logic/pe_mac.sv
// ========================================
// Signed MAC cell with operand forwarding
// ========================================
module pe_mac
    import accel_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_clr,
    input  logic signed [DATA_W-1:0]  i_a,
    input  logic                      i_a_vld,
    input  logic signed [DATA_W-1:0]  i_b,
    input  logic                      i_b_vld,
    output logic        [DATA_W-1:0]  o_a,
    output logic                      o_a_vld,
    output logic        [DATA_W-1:0]  o_b,
    output logic                      o_b_vld,
    output logic        [ACC_W-1:0]   o_acc
);

    logic signed [ACC_W-1:0] prod;

    // Sign extended before the multiply
    assign prod = ACC_W'(i_a) * ACC_W'(i_b);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_a_vld <= 1'b0;
            o_b_vld <= 1'b0;
            o_acc   <= '0;
        end else begin
            o_a_vld <= i_a_vld;
            o_b_vld <= i_b_vld;
            if (i_clr) begin
                o_acc <= '0;
            end else if (i_a_vld && i_b_vld) begin
                // Wraps at 32 bits
                o_acc <= o_acc + prod;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_a <= i_a;
        o_b <= i_b;
    end

endmodule

//--- logic/systolic_array.sv
// ========================================
// Input skew registers and the grid of
// output-stationary MAC cells
// ========================================
module systolic_array
    import accel_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_clr,
    input  logic                             i_en,
    input  logic [N_ROWS*DATA_W-1:0]         i_a_vec,
    input  logic [N_COLS*DATA_W-1:0]         i_b_vec,
    output logic [N_ROWS*N_COLS*ACC_W-1:0]   o_acc
);

    localparam int N_LANES = N_ROWS + N_COLS;

    // Rows occupy the low lanes, columns the high lanes
    logic [N_LANES*DATA_W-1:0] lane_in;
    logic [DATA_W-1:0]         lane_out [N_LANES];
    logic                      lane_vld [N_LANES];

    logic [DATA_W-1:0] a_h  [N_ROWS][N_COLS+1];
    logic              a_hv [N_ROWS][N_COLS+1];
    logic [DATA_W-1:0] b_v  [N_ROWS+1][N_COLS];
    logic              b_vv [N_ROWS+1][N_COLS];

    assign lane_in = {i_b_vec, i_a_vec};

    // ========================================
    // Skew: row i and column j delayed i / j
    // ========================================
    for (genvar l = 0; l < N_LANES; l++) begin : g_skew
        localparam int DLY = (l < N_ROWS) ? l : l - N_ROWS;
        if (DLY == 0) begin : g_pass
            assign lane_out[l] = lane_in[l*DATA_W +: DATA_W];
            assign lane_vld[l] = i_en;
        end else begin : g_dly
            logic [DATA_W-1:0] dat_q [DLY];
            logic [DLY-1:0]    vld_q;

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    vld_q <= '0;
                end else begin
                    vld_q[0] <= i_en;
                    for (int d = 1; d < DLY; d++) begin
                        vld_q[d] <= vld_q[d-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                dat_q[0] <= lane_in[l*DATA_W +: DATA_W];
                for (int d = 1; d < DLY; d++) begin
                    dat_q[d] <= dat_q[d-1];
                end
            end

            assign lane_out[l] = dat_q[DLY-1];
            assign lane_vld[l] = vld_q[DLY-1];
        end
    end

    // Array edges
    for (genvar i = 0; i < N_ROWS; i++) begin : g_west
        assign a_h[i][0]  = lane_out[i];
        assign a_hv[i][0] = lane_vld[i];
    end
    for (genvar j = 0; j < N_COLS; j++) begin : g_north
        assign b_v[0][j]  = lane_out[N_ROWS+j];
        assign b_vv[0][j] = lane_vld[N_ROWS+j];
    end

    // ========================================
    // PE grid, results flattened row-major
    // ========================================
    for (genvar i = 0; i < N_ROWS; i++) begin : g_row
        for (genvar j = 0; j < N_COLS; j++) begin : g_col
            pe_mac pe0 (
                .clk     (clk),
                .rst_n   (rst_n),
                .i_clr   (i_clr),
                .i_a     (a_h[i][j]),
                .i_a_vld (a_hv[i][j]),
                .i_b     (b_v[i][j]),
                .i_b_vld (b_vv[i][j]),
                .o_a     (a_h[i][j+1]),
                .o_a_vld (a_hv[i][j+1]),
                .o_b     (b_v[i+1][j]),
                .o_b_vld (b_vv[i+1][j]),
                .o_acc   (o_acc[(i*N_COLS+j)*ACC_W +: ACC_W])
            );
        end
    end

endmodule

//--- logic/tile_buffer.sv
// ========================================
// Two-bank lane vector buffer with one
// write port and a registered read port
// ========================================
module tile_buffer
    import accel_pkg::*;
#(
    parameter int LANES = 2
) (
    input  logic                     clk,
    // Write port
    input  logic                     i_we,
    input  logic [BUF_AW-1:0]        i_waddr,
    input  logic                     i_wbank,
    input  logic [LANES*DATA_W-1:0]  i_wdata,
    // Read port
    input  logic                     i_rd_en,
    input  logic [BUF_AW-1:0]        i_raddr,
    input  logic                     i_rbank,
    output logic [LANES*DATA_W-1:0]  o_rdata
);

    // Bank 0 and bank 1, each BUF_DEPTH entries
    logic [LANES*DATA_W-1:0] mem [2][BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wbank][i_waddr] <= i_wdata;
        end
    end

    // One cycle read latency, data held between reads
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rdata <= mem[i_rbank][i_raddr];
        end
    end

endmodule

//--- logic/tile_scheduler.sv
// ========================================
// Job FSM: buffer read sequencing, array
// clear/enable, busy and done
// ========================================
module tile_scheduler
    import accel_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_start,
    input  logic [K_W-1:0]      i_k_len,
    output logic                o_rd_en,
    output logic [BUF_AW-1:0]   o_rd_idx,
    output logic                o_arr_clr,
    output logic                o_arr_en,
    output logic                o_busy,
    output logic                o_done
);

    localparam int DW = $clog2(DRAIN_CYCLES);
    localparam logic [DW-1:0] DRAIN_LAST = DW'(DRAIN_CYCLES - 1);

    sched_state_e      state_q;
    logic [K_W-1:0]    k_cnt_q;
    logic [K_W-1:0]    k_len_q;
    logic [DW-1:0]     drain_q;
    logic              clr_q;
    logic              en_q;

    assign o_rd_en   = (state_q == ST_STREAM);
    assign o_rd_idx  = k_cnt_q[BUF_AW-1:0];
    assign o_arr_clr = clr_q;
    assign o_arr_en  = en_q;
    assign o_busy    = (state_q != ST_IDLE);
    assign o_done    = (state_q == ST_DONE);

    // K is captured at start so the register may change mid-job
    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && i_start) begin
            k_len_q <= i_k_len;
        end
    end

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            k_cnt_q <= '0;
            drain_q <= '0;
            clr_q   <= 1'b0;
            en_q    <= 1'b0;
        end else begin
            // Line up with buffer read latency
            clr_q <= (state_q == ST_CLEAR);
            en_q  <= (state_q == ST_STREAM);
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin
                        state_q <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    k_cnt_q <= '0;
                    drain_q <= '0;
                    // Empty reduction skips streaming
                    state_q <= (k_len_q == '0) ? ST_DRAIN : ST_STREAM;
                end
                ST_STREAM: begin
                    k_cnt_q <= k_cnt_q + 1'b1;
                    if (k_cnt_q == k_len_q - 1'b1) begin
                        state_q <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    drain_q <= drain_q + 1'b1;
                    if (drain_q == DRAIN_LAST) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/host_regs.sv
// ========================================
// Host command port, control and status
// registers, result readback and buffer
// write routing
// ========================================
module host_regs
    import accel_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    // Host command and response
    input  logic                             i_cmd_valid,
    output logic                             o_cmd_ready,
    input  cmd_op_e                          i_cmd_op,
    input  logic [CSR_AW-1:0]                i_cmd_addr,
    input  logic [REG_W-1:0]                 i_cmd_data,
    output logic                             o_rsp_valid,
    input  logic                             i_rsp_ready,
    output logic [REG_W-1:0]                 o_rsp_data,
    // Buffer writes
    output logic                             o_act_we,
    output logic [BUF_AW-1:0]                o_act_waddr,
    output logic [N_ROWS*DATA_W-1:0]         o_act_wdata,
    output logic                             o_act_wbank,
    output logic                             o_wgt_we,
    output logic [BUF_AW-1:0]                o_wgt_waddr,
    output logic [N_COLS*DATA_W-1:0]         o_wgt_wdata,
    output logic                             o_wgt_wbank,
    // Job control
    output logic                             o_start,
    output logic [K_W-1:0]                   o_k_len,
    output logic                             o_act_rbank,
    output logic                             o_wgt_rbank,
    input  logic                             i_busy,
    input  logic                             i_done,
    input  logic [N_ROWS*N_COLS*ACC_W-1:0]   i_acc,
    output logic                             o_busy,
    output logic                             o_done
);

    logic               accept;
    logic               reg_wr;
    logic               rd_req;
    logic               start_ok;
    logic [K_W-1:0]     k_len_q;
    logic [3:0]         bank_q;
    logic               done_q;
    logic [REG_W-1:0]   rd_mux;

    // Port stalls while a read response waits
    assign o_cmd_ready = ~o_rsp_valid;
    assign accept      = i_cmd_valid & o_cmd_ready;
    assign reg_wr      = accept && (i_cmd_op == OP_REG_WR);
    assign rd_req      = accept && (i_cmd_op == OP_REG_RD);

    // Pending start counts as busy so a back-to-back start is dropped
    assign o_busy   = i_busy | o_start;
    assign o_done   = i_done;
    assign start_ok = reg_wr && (i_cmd_addr == REG_CTRL) && i_cmd_data[0] && !o_busy;

    // ========================================
    // Buffer write routing
    // ========================================
    assign o_act_we    = accept && (i_cmd_op == OP_ACT_WR);
    assign o_act_waddr = i_cmd_addr[BUF_AW-1:0];
    assign o_act_wdata = i_cmd_data[N_ROWS*DATA_W-1:0];
    assign o_act_wbank = bank_q[0];

    assign o_wgt_we    = accept && (i_cmd_op == OP_WGT_WR);
    assign o_wgt_waddr = i_cmd_addr[BUF_AW-1:0];
    assign o_wgt_wdata = i_cmd_data[N_COLS*DATA_W-1:0];
    assign o_wgt_wbank = bank_q[1];

    assign o_act_rbank = bank_q[2];
    assign o_wgt_rbank = bank_q[3];
    assign o_k_len     = k_len_q;

    // ========================================
    // Control registers
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            k_len_q <= K_W'(1);
            bank_q  <= '0;
            done_q  <= 1'b0;
            o_start <= 1'b0;
        end else begin
            o_start <= start_ok;
            if (reg_wr && (i_cmd_addr == REG_K_LEN)) begin
                k_len_q <= i_cmd_data[K_W-1:0];
            end
            if (reg_wr && (i_cmd_addr == REG_BANK)) begin
                bank_q <= i_cmd_data[3:0];
            end
            // Sticky done, cleared by the next start
            if (start_ok) begin
                done_q <= 1'b0;
            end else if (i_done) begin
                done_q <= 1'b1;
            end
        end
    end

    // Read data select
    always_comb begin
        case (i_cmd_addr)
            REG_STATUS:  rd_mux = {{(REG_W-2){1'b0}}, done_q, o_busy};
            REG_K_LEN:   rd_mux = {{(REG_W-K_W){1'b0}}, k_len_q};
            REG_BANK:    rd_mux = {{(REG_W-4){1'b0}}, bank_q};
            REG_RESULT0: rd_mux = i_acc[0*ACC_W +: ACC_W];
            REG_RESULT1: rd_mux = i_acc[1*ACC_W +: ACC_W];
            REG_RESULT2: rd_mux = i_acc[2*ACC_W +: ACC_W];
            REG_RESULT3: rd_mux = i_acc[3*ACC_W +: ACC_W];
            default:     rd_mux = '0;
        endcase
    end

    // ========================================
    // Read response
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_rsp_valid <= 1'b0;
        end else if (rd_req) begin
            o_rsp_valid <= 1'b1;
        end else if (i_rsp_ready) begin
            o_rsp_valid <= 1'b0;
        end
    end

    // Held stable until the host takes it
    always_ff @(posedge clk) begin
        if (rd_req) begin
            o_rsp_data <= rd_mux;
        end
    end

endmodule

//--- logic/accel_top.sv
// ========================================
// Dense accelerator top: registers, two
// ping-pong buffers, scheduler and array
// ========================================
module accel_top
    import accel_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_cmd_valid,
    output logic               o_cmd_ready,
    input  cmd_op_e            i_cmd_op,
    input  logic [CSR_AW-1:0]  i_cmd_addr,
    input  logic [REG_W-1:0]   i_cmd_data,
    output logic               o_rsp_valid,
    input  logic               i_rsp_ready,
    output logic [REG_W-1:0]   o_rsp_data,
    output logic               o_busy,
    output logic               o_done
);

    // Buffer write side
    logic                            act_we;
    logic [BUF_AW-1:0]               act_waddr;
    logic [N_ROWS*DATA_W-1:0]        act_wdata;
    logic                            act_wbank;
    logic                            wgt_we;
    logic [BUF_AW-1:0]               wgt_waddr;
    logic [N_COLS*DATA_W-1:0]        wgt_wdata;
    logic                            wgt_wbank;
    // Job control
    logic                            start;
    logic [K_W-1:0]                  k_len;
    logic                            act_rbank;
    logic                            wgt_rbank;
    logic                            sched_busy;
    logic                            sched_done;
    // Datapath
    logic                            rd_en;
    logic [BUF_AW-1:0]               rd_idx;
    logic                            arr_clr;
    logic                            arr_en;
    logic [N_ROWS*DATA_W-1:0]        a_vec;
    logic [N_COLS*DATA_W-1:0]        b_vec;
    logic [N_ROWS*N_COLS*ACC_W-1:0]  acc;

    host_regs regs0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd_op    (i_cmd_op),
        .i_cmd_addr  (i_cmd_addr),
        .i_cmd_data  (i_cmd_data),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp_data  (o_rsp_data),
        .o_act_we    (act_we),
        .o_act_waddr (act_waddr),
        .o_act_wdata (act_wdata),
        .o_act_wbank (act_wbank),
        .o_wgt_we    (wgt_we),
        .o_wgt_waddr (wgt_waddr),
        .o_wgt_wdata (wgt_wdata),
        .o_wgt_wbank (wgt_wbank),
        .o_start     (start),
        .o_k_len     (k_len),
        .o_act_rbank (act_rbank),
        .o_wgt_rbank (wgt_rbank),
        .i_busy      (sched_busy),
        .i_done      (sched_done),
        .i_acc       (acc),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    tile_buffer #(.LANES(N_ROWS)) act_buf (
        .clk     (clk),
        .i_we    (act_we),
        .i_waddr (act_waddr),
        .i_wbank (act_wbank),
        .i_wdata (act_wdata),
        .i_rd_en (rd_en),
        .i_raddr (rd_idx),
        .i_rbank (act_rbank),
        .o_rdata (a_vec)
    );

    tile_buffer #(.LANES(N_COLS)) wgt_buf (
        .clk     (clk),
        .i_we    (wgt_we),
        .i_waddr (wgt_waddr),
        .i_wbank (wgt_wbank),
        .i_wdata (wgt_wdata),
        .i_rd_en (rd_en),
        .i_raddr (rd_idx),
        .i_rbank (wgt_rbank),
        .o_rdata (b_vec)
    );

    tile_scheduler sched0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_start   (start),
        .i_k_len   (k_len),
        .o_rd_en   (rd_en),
        .o_rd_idx  (rd_idx),
        .o_arr_clr (arr_clr),
        .o_arr_en  (arr_en),
        .o_busy    (sched_busy),
        .o_done    (sched_done)
    );

    systolic_array array0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_clr   (arr_clr),
        .i_en    (arr_en),
        .i_a_vec (a_vec),
        .i_b_vec (b_vec),
        .o_acc   (acc)
    );

endmodule

//--- verif/accel_tb.sv
// ========================================
// Testbench for accel_top with clock, reset,
// register and job tables, reference model,
// value checks and watchdog
// ========================================
module accel_tb
    import accel_pkg::*;
;

    localparam int N_REG_ROWS   = 11;
    localparam int N_JOBS       = 6;
    localparam int BP_CYCLES    = 4;
    localparam int OTHER_WRITES = 2;

    typedef struct packed {
        logic              wr;
        logic [CSR_AW-1:0] addr;
        logic [REG_W-1:0]  wdata;
        logic [REG_W-1:0]  rdata;
    } reg_row_t;

    typedef struct packed {
        logic [K_W-1:0] k_len;
        logic           a_bank;
        logic           w_bank;
        logic           bp;
    } job_row_t;

    logic              clk;
    logic              rst_n;
    logic              i_cmd_valid;
    logic              o_cmd_ready;
    cmd_op_e           i_cmd_op;
    logic [CSR_AW-1:0] i_cmd_addr;
    logic [REG_W-1:0]  i_cmd_data;
    logic              o_rsp_valid;
    logic              i_rsp_ready;
    logic [REG_W-1:0]  o_rsp_data;
    logic              o_busy;
    logic              o_done;

    integer seed = 32273;
    int     done_cnt = 0;
    int     jobs_started = 0;

    // Shadow copy of both banks by bank, entry and lane
    byte sh_a [2][BUF_DEPTH][N_ROWS];
    byte sh_b [2][BUF_DEPTH][N_COLS];

    // Write flag, address, write value, expected read value
    reg_row_t reg_tab [N_REG_ROWS] = '{
        '{1'b0, REG_STATUS,  32'h0000_0000, 32'h0000_0000},
        '{1'b0, REG_K_LEN,   32'h0000_0000, 32'h0000_0001},
        '{1'b0, REG_BANK,    32'h0000_0000, 32'h0000_0000},
        '{1'b0, 8'h20,       32'h0000_0000, 32'h0000_0000},
        '{1'b0, 8'h02,       32'h0000_0000, 32'h0000_0000},
        '{1'b1, REG_K_LEN,   32'hFFFF_FFE7, 32'h0000_0007},
        '{1'b1, REG_BANK,    32'hABCD_EF5A, 32'h0000_000A},
        '{1'b1, REG_STATUS,  32'h0000_0003, 32'h0000_0000},
        '{1'b1, REG_RESULT0, 32'h1234_5678, 32'h0000_0000},
        '{1'b1, REG_RESULT3, 32'hDEAD_BEEF, 32'h0000_0000},
        '{1'b1, 8'h40,       32'hFFFF_FFFF, 32'h0000_0000}
    };

    // K, act read bank, wgt read bank, response back-pressure
    job_row_t job_tab [N_JOBS] = '{
        '{5'd4,  1'b0, 1'b0, 1'b0},
        '{5'd16, 1'b1, 1'b1, 1'b1},
        '{5'd0,  1'b0, 1'b1, 1'b0},
        '{5'd7,  1'b1, 1'b0, 1'b1},
        '{5'd1,  1'b0, 1'b0, 1'b0},
        '{5'd8,  1'b1, 1'b1, 1'b0}
    };

    accel_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd_op    (i_cmd_op),
        .i_cmd_addr  (i_cmd_addr),
        .i_cmd_data  (i_cmd_data),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp_data  (o_rsp_data),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Count done pulses away from the clock edge
    always @(negedge clk) begin
        if (rst_n && o_done) begin
            done_cnt++;
        end
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic check_value(input string name, input logic [REG_W-1:0] actual,
                               input logic [REG_W-1:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    // Called 1 unit after an edge; returns 1 unit after the accepting edge
    task automatic send_cmd(input cmd_op_e op, input logic [CSR_AW-1:0] addr,
                            input logic [REG_W-1:0] data);
        i_cmd_valid = 1'b1;
        i_cmd_op    = op;
        i_cmd_addr  = addr;
        i_cmd_data  = data;
        while (!o_cmd_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        i_cmd_valid = 1'b0;
    endtask

    task automatic read_reg(input logic [CSR_AW-1:0] addr, input int hold,
                            output logic [REG_W-1:0] data);
        logic [REG_W-1:0] first;
        i_rsp_ready = (hold == 0);
        send_cmd(OP_REG_RD, addr, '0);
        check_value("o_rsp_valid", REG_W'(o_rsp_valid), 32'h1);
        first = o_rsp_data;
        // Response must hold still while the host stalls
        for (int c = 0; c < hold; c++) begin
            @(posedge clk);
            #1;
            check_value("o_rsp_valid", REG_W'(o_rsp_valid), 32'h1);
            check_value("o_rsp_data", o_rsp_data, first);
            check_value("o_cmd_ready", REG_W'(o_cmd_ready), 32'h0);
        end
        i_rsp_ready = 1'b1;
        @(posedge clk);
        #1;
        check_value("o_rsp_valid", REG_W'(o_rsp_valid), 32'h0);
        data = first;
    endtask

    task automatic load_entry(input logic is_act, input logic bank, input int k);
        byte l0;
        byte l1;
        l0 = byte'($random(seed));
        l1 = byte'($random(seed));
        if (is_act) begin
            sh_a[bank][k][0] = l0;
            sh_a[bank][k][1] = l1;
            send_cmd(OP_ACT_WR, CSR_AW'(k), REG_W'({l1, l0}));
        end else begin
            sh_b[bank][k][0] = l0;
            sh_b[bank][k][1] = l1;
            send_cmd(OP_WGT_WR, CSR_AW'(k), REG_W'({l1, l0}));
        end
    endtask

    // C[i][j] is the wrapping 32-bit sum over k of A[i][k] * B[k][j]
    function automatic logic [REG_W-1:0] model_result(input int i, input int j,
                                                      input job_row_t row);
        int sum;
        int prod;
        sum = 0;
        for (int k = 0; k < int'(row.k_len); k++) begin
            prod = sh_a[row.a_bank][k][i] * sh_b[row.w_bank][k][j];
            sum  = sum + prod;
        end
        return REG_W'(sum);
    endfunction

    // Returns 1 unit into the cycle where o_done is high
    task automatic wait_done_cycle();
        while (!o_done) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_job(input job_row_t row);
        logic [REG_W-1:0] exp_c [N_ROWS*N_COLS];
        logic [REG_W-1:0] rd;
        int               hold;
        // Load the banks this job reads
        send_cmd(OP_REG_WR, REG_BANK,
                 REG_W'({row.w_bank, row.a_bank, row.w_bank, row.a_bank}));
        for (int k = 0; k < int'(row.k_len); k++) begin
            load_entry(1'b1, row.a_bank, k);
            load_entry(1'b0, row.w_bank, k);
        end
        send_cmd(OP_REG_WR, REG_K_LEN, REG_W'(row.k_len));
        // Point writes at the idle banks
        send_cmd(OP_REG_WR, REG_BANK,
                 REG_W'({row.w_bank, row.a_bank, ~row.w_bank, ~row.a_bank}));
        for (int r = 0; r < N_ROWS * N_COLS; r++) begin
            exp_c[r] = model_result(r / N_COLS, r % N_COLS, row);
        end
        jobs_started++;
        send_cmd(OP_REG_WR, REG_CTRL, 32'h1);
        check_value("o_busy", REG_W'(o_busy), 32'h1);
        // This one arrives while busy and must be dropped
        send_cmd(OP_REG_WR, REG_CTRL, 32'h1);
        for (int k = 0; k < OTHER_WRITES; k++) begin
            load_entry(1'b1, ~row.a_bank, k);
            load_entry(1'b0, ~row.w_bank, k);
        end
        wait_done_cycle();
        // Still busy in the done cycle, so this start is dropped too
        send_cmd(OP_REG_WR, REG_CTRL, 32'h1);
        read_reg(REG_STATUS, 0, rd);
        check_value("o_rsp_data(STATUS)", rd, 32'h2);
        for (int r = 0; r < N_ROWS * N_COLS; r++) begin
            hold = (row.bp && r == 0) ? BP_CYCLES : 0;
            read_reg(CSR_AW'(int'(REG_RESULT0) + 4 * r), hold, rd);
            check_value($sformatf("o_rsp_data(RESULT%0d)", r), rd, exp_c[r]);
        end
        check_value("o_done pulse count", REG_W'(done_cnt), REG_W'(jobs_started));
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        logic [REG_W-1:0] rd;
        rst_n       = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd_op    = OP_REG_WR;
        i_cmd_addr  = '0;
        i_cmd_data  = '0;
        i_rsp_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_value("o_busy", REG_W'(o_busy), 32'h0);
        check_value("o_done", REG_W'(o_done), 32'h0);
        check_value("o_rsp_valid", REG_W'(o_rsp_valid), 32'h0);
        check_value("o_cmd_ready", REG_W'(o_cmd_ready), 32'h1);

        for (int r = 0; r < N_REG_ROWS; r++) begin
            if (reg_tab[r].wr) begin
                send_cmd(OP_REG_WR, reg_tab[r].addr, reg_tab[r].wdata);
            end
            read_reg(reg_tab[r].addr, 0, rd);
            check_value($sformatf("o_rsp_data(0x%02h)", reg_tab[r].addr), rd,
                        reg_tab[r].rdata);
        end

        for (int j = 0; j < N_JOBS; j++) begin
            run_job(job_tab[j]);
        end

        $display("Finished with no errors");
        $finish;
    end

    // Watchdog scaled by the job table
    initial begin
        int total_k;
        total_k = 0;
        for (int j = 0; j < N_JOBS; j++) begin
            total_k += int'(job_tab[j].k_len);
        end
        #((total_k + 20 * N_JOBS + 200) * 10);
        $display("Timeout: the run did not complete in the allowed time");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- sim.f
logic/accel_pkg.sv
logic/pe_mac.sv
logic/systolic_array.sv
logic/tile_buffer.sv
logic/tile_scheduler.sv
logic/host_regs.sv
logic/accel_top.sv
verif/accel_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the accelerator simulation with Verilator.
# The exit status of the simulation binary is the pass/fail result.
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal \
    --top-module accel_tb \
    -Mdir obj_dir \
    -f sim.f

./obj_dir/Vaccel_tb
